// File: direction_predictor.sv
// Direction predictor built from three tables of 2-bit words, one bit
// per slot; the prediction is the XOR of the three words read.
// Indices: a = {ip[9:4], ght[1:0]}, b = {ip[7:4], ght[3:0]},
// c = {ip[5:4], ght[5:0]}. Needs ip_w >= 10 and ght_w >= 6.
// Training happens only on cond mispredicts and is driven by a miss
// counter, so table b flips every 4th and table c every 16th miss.
`timescale 1ns/1ns

module direction_predictor #(
  parameter int ip_w  = 32,
  parameter int ght_w = 8
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [ip_w-1:0]                fetch_ip,
  input  logic [ght_w-1:0]               fetch_ght,
  input  frontend_pkg::retire_t          retire,
  output logic [frontend_pkg::slots-1:0] dir
);

  localparam int n_tbl   = 3;
  localparam int idx_w   = frontend_pkg::pred_idx_w;
  localparam int entries = 1 << idx_w;

  logic [frontend_pkg::slots-1:0] tbl [n_tbl][entries];

  logic [3:0]                     miss_cnt;
  logic                           train;
  logic [n_tbl-1:0]               flip_sel;
  logic [frontend_pkg::slots-1:0] slot_mask;

  // ip_bits is ip[9:4]
  function automatic logic [idx_w-1:0] tbl_idx(
    input logic [5:0] ip_bits,
    input logic [5:0] hist,
    input int         t
  );
    case (t)
      0:       tbl_idx = {ip_bits[5:0], hist[1:0]};
      1:       tbl_idx = {ip_bits[3:0], hist[3:0]};
      default: tbl_idx = {ip_bits[1:0], hist[5:0]};
    endcase
  endfunction

  always_comb begin
    dir = '0;
    for (int t = 0; t < n_tbl; t++) begin
      dir ^= tbl[t][tbl_idx(fetch_ip[9:4], fetch_ght[5:0], t)];
    end
  end

  assign train = retire.valid && retire.mispredict &&
                 (retire.kind == frontend_pkg::cond);

  // a always, b and c gated by the old counter value
  assign flip_sel = {&miss_cnt[3:0], &miss_cnt[1:0], 1'b1};

  always_comb begin
    slot_mask = '0;
    slot_mask[retire.slot] = 1'b1;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      miss_cnt <= '0;
      for (int t = 0; t < n_tbl; t++) begin
        for (int i = 0; i < entries; i++) begin
          tbl[t][i] <= '0;
        end
      end
    end else if (train) begin
      miss_cnt <= miss_cnt + 1'b1;
      for (int t = 0; t < n_tbl; t++) begin
        if (flip_sel[t]) begin
          tbl[t][tbl_idx(retire.src_ip[9:4], retire.ght[5:0], t)] <=
            tbl[t][tbl_idx(retire.src_ip[9:4], retire.ght[5:0], t)] ^ slot_mask;
        end
      end
    end
  end

endmodule

// File: fetch_checker.sv
// Concurrent checks on the fetch sequencer, bound into every instance.
// Failures raise $error and bump fail_count, which the testbench reads
// through the bound instance u_chk.
`timescale 1ns/1ns

module fetch_checker #(
  parameter int ip_w = 32
) (
  input logic                           clk,
  input logic                           rst,
  input logic [ip_w-1:0]                fetch_ip,
  input frontend_pkg::retire_t          retire,
  input logic [frontend_pkg::slots-1:0] hit,
  input frontend_pkg::pred_t            pred
);

  localparam int lsb = frontend_pkg::line_lsb;

  int   fail_count = 0;
  logic redirect;

  assign redirect = retire.valid && retire.mispredict;

  line_aligned: assert property (@(posedge clk) disable iff (rst)
    fetch_ip[lsb-1:0] == '0)
    else begin
      fail_count++;
      $error("fetch_ip %h is not on a line boundary", fetch_ip);
    end

  // redirect lands on the line of the retired target
  redirect_target: assert property (@(posedge clk) disable iff (rst)
    redirect |=> fetch_ip[ip_w-1:lsb] == $past(retire.target[ip_w-1:lsb]))
    else begin
      fail_count++;
      $error("fetch_ip %h does not follow the mispredict target", fetch_ip);
    end

  taken_has_hit: assert property (@(posedge clk) disable iff (rst)
    pred.taken |-> |hit)
    else begin
      fail_count++;
      $error("prediction taken with no target buffer hit");
    end

endmodule

bind fetch_sequencer fetch_checker #(.ip_w(ip_w)) u_chk (
  .clk      (clk),
  .rst      (rst),
  .fetch_ip (fetch_ip),
  .retire   (retire),
  .hit      (hit),
  .pred     (pred)
);

// File: fetch_frontend.f
frontend_pkg.sv
target_buffer.sv
direction_predictor.sv
return_stack.sv
fetch_sequencer.sv
fetch_top.sv
fetch_checker.sv
fetch_tb.sv

// File: fetch_golden.txt
// one line per cycle after reset, all fields hex
// retire: valid mispredict slot kind src_ip target ght, then expected fetch_ip taken slot
// kind 0 cond, 1 uncond, 2 call, 3 ret
0 0 0 0 00000000 00000000 00 00001000 0 0
0 0 0 0 00000000 00000000 00 00001010 0 0
0 0 0 0 00000000 00000000 00 00001020 0 0
1 1 0 1 00001040 00001200 00 00001030 0 0
1 1 1 1 00001200 00001030 00 00001200 0 0
0 0 0 0 00000000 00000000 00 00001030 0 0
0 0 0 0 00000000 00000000 00 00001040 1 0
0 0 0 0 00000000 00000000 00 00001200 1 1
0 0 0 0 00000000 00000000 00 00001030 0 0
1 1 0 2 00002000 00003050 00 00001040 1 0
1 1 0 3 00003050 00002000 00 00003050 0 0
0 0 0 0 00000000 00000000 00 00002000 1 0
0 0 0 0 00000000 00000000 00 00003050 1 0
1 1 0 0 00004060 00004060 00 00002010 0 0
1 1 0 0 00004060 00004060 00 00004060 1 0
1 1 0 0 00004060 00004060 00 00004060 0 0
1 1 0 0 00004060 00004060 00 00004060 1 0
1 1 0 0 00004060 00004060 00 00004060 1 0
1 1 0 0 00004060 00004060 00 00004060 0 0
1 1 0 0 00004060 00004060 00 00004060 1 0
1 1 0 0 00004060 00004060 00 00004060 0 0
1 1 0 0 00004060 00004060 00 00004060 0 0
1 1 0 0 00004060 00004060 00 00004060 1 0
1 1 0 0 00004060 00004060 00 00004060 0 0
1 1 0 0 00004060 00004060 00 00004060 1 0
1 1 0 0 00004060 00004060 00 00004060 1 0
1 1 0 0 00004060 00004060 00 00004060 0 0
1 1 0 0 00004060 00004060 00 00004060 1 0
1 1 0 0 00004060 00004060 00 00004060 0 0
1 1 1 1 00005088 00006000 00 00004060 1 0
1 1 0 1 00005084 00005100 00 00006000 0 0
1 1 1 1 00005100 00005070 00 00005100 0 0
0 0 0 0 00000000 00000000 00 00005070 0 0
0 0 0 0 00000000 00000000 00 00005080 1 0
0 0 0 0 00000000 00000000 00 00005100 1 1
0 0 0 0 00000000 00000000 00 00005070 0 0
0 0 0 0 00000000 00000000 00 00005080 1 0

// File: fetch_sequencer.sv
// Fetch sequencer: holds the fetch ip and global history, picks the
// first taken slot of the current line and chooses the next ip.
// A retire mispredict wins over the prediction in the same cycle and
// suppresses the stack push/pop of the discarded path.
// Next ips are line addresses, the low four bits of targets are dropped.
// ght_w must be between 6 and the package history width.
`timescale 1ns/1ns

module fetch_sequencer #(
  parameter int              ip_w     = 32,
  parameter int              ght_w    = 8,
  parameter logic [ip_w-1:0] reset_ip = 32'h0000_1000
) (
  input  logic                                             clk,
  input  logic                                             rst,
  input  logic [frontend_pkg::slots-1:0]                   hit,
  input  frontend_pkg::tb_entry_t [frontend_pkg::slots-1:0] entry,
  input  logic [frontend_pkg::slots-1:0]                   dir,
  input  logic [ip_w-1:0]                                  top,
  input  frontend_pkg::retire_t                            retire,
  output logic                                             push,
  output logic [ip_w-1:0]                                  push_addr,
  output logic                                             pop,
  output logic [ip_w-1:0]                                  fetch_ip,
  output logic [ght_w-1:0]                                 fetch_ght,
  output frontend_pkg::pred_t                              pred
);

  localparam int lsb = frontend_pkg::line_lsb;

  logic [frontend_pkg::slots-1:0]  take;
  logic [frontend_pkg::slot_w-1:0] pick;
  frontend_pkg::tb_entry_t         pick_e;
  logic [ip_w-1:0]                 line_next;
  logic                            redirect;

  assign line_next = fetch_ip + ip_w'(frontend_pkg::line_bytes);
  assign redirect  = retire.valid && retire.mispredict;

  always_comb begin
    take = '0;
    pick = '0;
    for (int s = 0; s < frontend_pkg::slots; s++) begin
      take[s] = hit[s] && (entry[s].kind != frontend_pkg::cond || dir[s]);
    end
    // walk down so the lowest taken slot wins
    for (int s = frontend_pkg::slots - 1; s >= 0; s--) begin
      if (take[s]) pick = s[frontend_pkg::slot_w-1:0];
    end
    pick_e      = entry[pick];
    pred.taken  = |take;
    pred.slot   = pick;
    pred.target = (pick_e.kind == frontend_pkg::ret) ? top : pick_e.target;
  end

  assign push      = !redirect && pred.taken && (pick_e.kind == frontend_pkg::call);
  assign pop       = !redirect && pred.taken && (pick_e.kind == frontend_pkg::ret);
  assign push_addr = line_next;   // return lands on the next line

  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_ip  <= reset_ip;
      fetch_ght <= '0;
    end else if (redirect) begin
      fetch_ip  <= {retire.target[ip_w-1:lsb], {lsb{1'b0}}};
      fetch_ght <= retire.ght[ght_w-1:0];
    end else begin
      if (pred.taken) begin
        fetch_ip <= {pred.target[ip_w-1:lsb], {lsb{1'b0}}};
      end else begin
        fetch_ip <= line_next;
      end
      if (|hit) fetch_ght <= {fetch_ght[ght_w-2:0], pred.taken};  // history moves on hits only
    end
  end

endmodule

// File: fetch_tb.sv
// Testbench for fetch_top, driven line by line from fetch_golden.txt.
// Each golden line is one cycle after reset: the retire fields go in
// 1 ns after the edge, fetch_ip, fetch_ght and pred are checked 2 ns later.
// Run from the project root so the golden file path resolves.
`timescale 1ns/1ns

module fetch_tb;

  localparam int lsb     = frontend_pkg::line_lsb;
  localparam int tb_keys = (1 << frontend_pkg::tb_idx_w) * frontend_pkg::slots;

  typedef struct packed {
    frontend_pkg::retire_t             retire;
    logic [31:0]                       ip;
    logic                              taken;
    logic [frontend_pkg::slot_w-1:0]   slot;
  } golden_t;

  logic                  clk;
  logic                  rst;
  frontend_pkg::retire_t retire;
  logic [31:0]           fetch_ip;
  logic [7:0]            fetch_ght;
  frontend_pkg::pred_t   pred;

  golden_t golden_q[$];
  int      checks       = 0;
  int      mismatches   = 0;
  int      other_errors = 0;
  int      cycle_count  = 0;
  int      cycle_limit  = 20;

  // installed branch address per buffer line and slot, plus expected history
  logic        key_used [tb_keys];
  logic [31:0] key_line [tb_keys];
  logic [7:0]  exp_ght;

  fetch_top UUT (
    .clk       (clk),
    .rst       (rst),
    .retire    (retire),
    .fetch_ip  (fetch_ip),
    .fetch_ght (fetch_ght),
    .pred      (pred)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  task automatic finish_run();
    int total;
    total = mismatches + other_errors + UUT.u_seq.u_chk.fail_count;
    $display("checks %0d, mismatches %0d, other errors %0d, assertion failures %0d",
             checks, mismatches, other_errors, UUT.u_seq.u_chk.fail_count);
    if (total == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  endtask

  // limit covers reset plus every golden line
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      other_errors++;
      $display("run did not finish within %0d cycles", cycle_limit);
      finish_run();
    end
  end

  task automatic load_golden();
    int          fd;
    int          n;
    int          line_no;
    string       text;
    logic [31:0] f_valid, f_mp, f_slot, f_kind, f_src;
    logic [31:0] f_tgt, f_ght, f_ip, f_taken, f_pslot;
    golden_t     g;
    fd = $fopen("fetch_golden.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("golden file fetch_golden.txt could not be opened");
      return;
    end
    line_no = 0;
    while (!$feof(fd)) begin
      text = "";
      n = $fgets(text, fd);
      line_no++;
      n = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h", f_valid, f_mp, f_slot,
                  f_kind, f_src, f_tgt, f_ght, f_ip, f_taken, f_pslot);
      if (n == 10) begin
        g.retire.valid      = f_valid[0];
        g.retire.mispredict = f_mp[0];
        g.retire.slot       = f_slot[frontend_pkg::slot_w-1:0];
        g.retire.kind       = frontend_pkg::branch_kind_t'(f_kind[1:0]);
        g.retire.src_ip     = f_src;
        g.retire.target     = f_tgt;
        g.retire.ght        = f_ght[frontend_pkg::hist_w-1:0];
        g.ip                = f_ip;
        g.taken             = f_taken[0];
        g.slot              = f_pslot[frontend_pkg::slot_w-1:0];
        golden_q.push_back(g);
      end else if (n > 0) begin  // comments and blank lines give 0 or -1
        other_errors++;
        $display("golden file line %0d is short, %0d of 10 fields", line_no, n);
      end
    end
    $fclose(fd);
    if (golden_q.size() == 0) begin
      other_errors++;
      $display("golden file holds no stimulus lines");
    end
  endtask

  task automatic check_outputs(input int i);
    golden_t g;
    g = golden_q[i];
    checks++;
    assert (fetch_ip == g.ip) else begin
      mismatches++;
      $display("Mismatch at %0t ns: fetch_ip is %h, expected %h", $time, fetch_ip, g.ip);
    end
    assert (pred.taken == g.taken) else begin
      mismatches++;
      $display("Mismatch at %0t ns: pred.taken is %b, expected %b",
               $time, pred.taken, g.taken);
    end
    assert (pred.slot == g.slot) else begin
      mismatches++;
      $display("Mismatch at %0t ns: pred.slot is %0d, expected %0d",
               $time, pred.slot, g.slot);
    end
    assert (fetch_ght == exp_ght) else begin
      mismatches++;
      $display("Mismatch at %0t ns: fetch_ght is %h, expected %h",
               $time, fetch_ght, exp_ght);
    end
    // next golden ip is the target line when taken with no redirect
    if (g.taken && !(g.retire.valid && g.retire.mispredict) &&
        i + 1 < golden_q.size()) begin
      assert (pred.target[31:lsb] == golden_q[i + 1].ip[31:lsb]) else begin
        mismatches++;
        $display("Mismatch at %0t ns: pred.target is %h, expected line %h",
                 $time, pred.target, golden_q[i + 1].ip);
      end
    end
  endtask

  // history and buffer contents that follow the cycle of golden entry g
  task automatic advance_model(input golden_t g);
    int   base;
    int   key;
    logic line_hit;
    base     = g.ip[lsb +: frontend_pkg::tb_idx_w] * frontend_pkg::slots;
    key      = g.retire.src_ip[lsb +: frontend_pkg::tb_idx_w] * frontend_pkg::slots
               + g.retire.slot;
    line_hit = 1'b0;
    for (int s = 0; s < frontend_pkg::slots; s++) begin
      if (key_used[base + s] && key_line[base + s][31:lsb] == g.ip[31:lsb]) line_hit = 1'b1;
    end
    if (g.retire.valid && g.retire.mispredict) begin
      exp_ght       = g.retire.ght;
      key_used[key] = 1'b1;
      key_line[key] = g.retire.src_ip;
    end else if (line_hit) begin
      exp_ght = {exp_ght[6:0], g.taken};
    end
  endtask

  task automatic run_golden();
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    foreach (golden_q[i]) begin
      retire = golden_q[i].retire;
      #2;
      check_outputs(i);
      advance_model(golden_q[i]);
      @(posedge clk);
      #1;
    end
    retire = '0;
  endtask

  initial begin
    rst     = 1'b1;
    retire  = '0;
    exp_ght = '0;
    foreach (key_used[k]) begin
      key_used[k] = 1'b0;
    end
    load_golden();
    cycle_limit = golden_q.size() + 20;
    if (other_errors == 0) begin
      run_golden();
    end
    finish_run();
  end

endmodule

// File: fetch_top.sv
// Top of the fetch unit: sequencer plus target buffer, direction
// predictor and return stack. One line fetched every cycle with no
// stall input; retire is a one-cycle strobe inside the struct.
// ip_w and tb_idx_w must match the package widths.
`timescale 1ns/1ns

module fetch_top #(
  parameter int              ip_w      = 32,
  parameter int              tb_idx_w  = 6,
  parameter int              ght_w     = 8,
  parameter int              ras_depth = 16,
  parameter logic [ip_w-1:0] reset_ip  = 32'h0000_1000
) (
  input  logic                  clk,
  input  logic                  rst,
  input  frontend_pkg::retire_t retire,
  output logic [ip_w-1:0]       fetch_ip,
  output logic [ght_w-1:0]      fetch_ght,
  output frontend_pkg::pred_t   pred
);

  logic [frontend_pkg::slots-1:0]                   hit;
  frontend_pkg::tb_entry_t [frontend_pkg::slots-1:0] entry;
  logic [frontend_pkg::slots-1:0]                   dir;
  logic [ip_w-1:0]                                  top;
  logic                                             push;
  logic [ip_w-1:0]                                  push_addr;
  logic                                             pop;

  target_buffer #(.ip_w(ip_w), .tb_idx_w(tb_idx_w)) u_tb (
    .clk      (clk),
    .rst      (rst),
    .fetch_ip (fetch_ip),
    .retire   (retire),
    .hit      (hit),
    .entry    (entry)
  );

  direction_predictor #(.ip_w(ip_w), .ght_w(ght_w)) u_dp (
    .clk       (clk),
    .rst       (rst),
    .fetch_ip  (fetch_ip),
    .fetch_ght (fetch_ght),
    .retire    (retire),
    .dir       (dir)
  );

  return_stack #(.ip_w(ip_w), .ras_depth(ras_depth)) u_ras (
    .clk       (clk),
    .rst       (rst),
    .push      (push),
    .push_addr (push_addr),
    .pop       (pop),
    .top       (top)
  );

  fetch_sequencer #(.ip_w(ip_w), .ght_w(ght_w), .reset_ip(reset_ip)) u_seq (
    .clk       (clk),
    .rst       (rst),
    .hit       (hit),
    .entry     (entry),
    .dir       (dir),
    .top       (top),
    .retire    (retire),
    .push      (push),
    .push_addr (push_addr),
    .pop       (pop),
    .fetch_ip  (fetch_ip),
    .fetch_ght (fetch_ght),
    .pred      (pred)
  );

endmodule

// File: frontend_pkg.sv
// Shared types and fixed widths for the branch-predicting fetch unit.
// Widths here are fixed; the module parameters set in fetch_top must
// agree with ip_w and tb_idx_w below, and ght_w must not exceed hist_w.
// Fetch works on 16-byte lines with two branch slots per line.
package frontend_pkg;

  localparam int line_bytes = 16;
  localparam int line_lsb   = $clog2(line_bytes);
  localparam int slots      = 2;
  localparam int slot_w     = $clog2(slots);
  localparam int pred_idx_w = 8;   // index of each predictor table

  localparam int ip_w     = 32;
  localparam int tb_idx_w = 6;
  localparam int tag_w    = ip_w - line_lsb - tb_idx_w;  // ip bits above the line index
  localparam int hist_w   = 8;     // history carried on retire

  typedef enum logic [1:0] {
    cond   = 2'd0,
    uncond = 2'd1,
    call   = 2'd2,
    ret    = 2'd3
  } branch_kind_t;

  // one target buffer slot
  typedef struct packed {
    logic              valid;
    branch_kind_t      kind;
    logic [tag_w-1:0]  tag;
    logic [ip_w-1:0]   target;
  } tb_entry_t;

  // retire report, counts only in the cycle valid is high
  typedef struct packed {
    logic              valid;
    logic              mispredict;
    logic [slot_w-1:0] slot;
    branch_kind_t      kind;
    logic [ip_w-1:0]   src_ip;   // address of the branch
    logic [ip_w-1:0]   target;   // resolved next ip
    logic [hist_w-1:0] ght;      // history to restore
  } retire_t;

  typedef struct packed {
    logic              taken;
    logic [slot_w-1:0] slot;
    logic [ip_w-1:0]   target;
  } pred_t;

endpackage

// File: return_stack.sv
// Circular return address stack. Overflow silently wraps over the
// oldest entry and underflow wraps the pointer; nothing is flagged.
// Not repaired after a mispredict.
// ras_depth must be a power of two, at least 2.
`timescale 1ns/1ns

module return_stack #(
  parameter int ip_w      = 32,
  parameter int ras_depth = 16
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            push,
  input  logic [ip_w-1:0] push_addr,
  input  logic            pop,
  output logic [ip_w-1:0] top
);

  localparam int ptr_w = $clog2(ras_depth);

  logic [ip_w-1:0]  stack [ras_depth];
  logic [ptr_w-1:0] sp;       // slot holding the current top
  logic [ptr_w-1:0] sp_up;
  logic [ptr_w-1:0] sp_down;

  assign sp_up   = sp + 1'b1;
  assign sp_down = sp - 1'b1;

  assign top = stack[sp];

  // push and pop never arrive together, one kind per chosen slot
  always_ff @(posedge clk) begin
    if (rst) begin
      sp <= '0;
      for (int i = 0; i < ras_depth; i++) begin
        stack[i] <= '0;
      end
    end else if (push) begin
      stack[sp_up] <= push_addr;
      sp           <= sp_up;
    end else if (pop) begin
      sp <= sp_down;
    end
  end

endmodule

// File: target_buffer.sv
// Branch target buffer, two slots per 16-byte line, direct mapped.
// Lookup is combinational on fetch_ip; an install on a retire
// mispredict is seen from the next cycle on.
// ip_w and tb_idx_w must match the package so tag widths agree.
// Install always overwrites the reported slot, no replacement policy.
`timescale 1ns/1ns

module target_buffer #(
  parameter int ip_w     = 32,
  parameter int tb_idx_w = 6
) (
  input  logic                                             clk,
  input  logic                                             rst,
  input  logic [ip_w-1:0]                                  fetch_ip,
  input  frontend_pkg::retire_t                            retire,
  output logic [frontend_pkg::slots-1:0]                   hit,
  output frontend_pkg::tb_entry_t [frontend_pkg::slots-1:0] entry
);

  localparam int lines = 1 << tb_idx_w;
  localparam int lsb   = frontend_pkg::line_lsb;
  localparam int tag_w = ip_w - lsb - tb_idx_w;

  frontend_pkg::tb_entry_t [frontend_pkg::slots-1:0] mem [lines];

  logic [tb_idx_w-1:0] rd_idx;
  logic [tb_idx_w-1:0] wr_idx;
  logic [tag_w-1:0]    rd_tag;
  logic [tag_w-1:0]    wr_tag;
  logic                install;

  assign rd_idx = fetch_ip[lsb +: tb_idx_w];
  assign rd_tag = fetch_ip[ip_w-1 : lsb+tb_idx_w];

  // install address comes from the branch itself, not the fetch ip
  assign wr_idx  = retire.src_ip[lsb +: tb_idx_w];
  assign wr_tag  = retire.src_ip[ip_w-1 : lsb+tb_idx_w];
  assign install = retire.valid && retire.mispredict;

  assign entry = mem[rd_idx];

  always_comb begin
    for (int s = 0; s < frontend_pkg::slots; s++) begin
      hit[s] = entry[s].valid && (entry[s].tag == rd_tag);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < lines; i++) begin
        mem[i] <= '0;
      end
    end else if (install) begin
      mem[wr_idx][retire.slot] <= '{
        valid:  1'b1,
        kind:   retire.kind,
        tag:    wr_tag,
        target: retire.target
      };
    end
  end

endmodule
